// ==== source/crypto_pkg.sv ====
/*
 * Shared definitions for the RV64 SHA-2 scalar crypto unit.
 * Data widths, the decoded opcode enum and the instruction-field
 * constants used by decode and by the testbench.
 */
package crypto_pkg;

    //------------------------------------------------------------
    // Widths
    //------------------------------------------------------------

    // Register width, RV64 only
    localparam int xlen     = 64;
    // Instruction word width
    localparam int word_w   = 32;
    // SHA-256 operates on a 32-bit word
    localparam int sha256_w = 32;

    //------------------------------------------------------------
    // Decoded operations
    //------------------------------------------------------------

    typedef enum logic [3:0] {
        op_none       = 4'd0,
        op_sha256sig0 = 4'd1,
        op_sha256sig1 = 4'd2,
        op_sha256sum0 = 4'd3,
        op_sha256sum1 = 4'd4,
        op_sha512sig0 = 4'd5,
        op_sha512sig1 = 4'd6,
        op_sha512sum0 = 4'd7,
        op_sha512sum1 = 4'd8
    } crypto_op_e;

    //------------------------------------------------------------
    // Instruction fields
    //------------------------------------------------------------

    // OP-IMM major opcode, bits 6..0
    localparam logic [6:0] opc_op_imm = 7'h13;
    // funct3, bits 14..12
    localparam logic [2:0] funct3_sha = 3'd1;

    // Bits 31..20 select the function
    localparam logic [11:0] imm_sha256sum0 = 12'h100;
    localparam logic [11:0] imm_sha256sum1 = 12'h101;
    localparam logic [11:0] imm_sha256sig0 = 12'h102;
    localparam logic [11:0] imm_sha256sig1 = 12'h103;
    localparam logic [11:0] imm_sha512sum0 = 12'h104;
    localparam logic [11:0] imm_sha512sum1 = 12'h105;
    localparam logic [11:0] imm_sha512sig0 = 12'h106;
    localparam logic [11:0] imm_sha512sig1 = 12'h107;

endpackage

// ==== source/crypto_op_if.sv ====
/*
 * Decoded operation bus from decode to execute.
 * Carries the valid and illegal strobes, the opcode and rs1.
 */
`timescale 1ns/1ps

interface crypto_op_if;
    import crypto_pkg::*;

    // Single-cycle strobe, operation is legal
    logic               op_valid;
    // Decoded function
    crypto_op_e         op;
    // Source operand, only meaningful with op_valid
    logic [xlen-1:0]    op_rs1;
    // Single-cycle strobe, word not recognised
    logic               op_illegal;

    // Producer side
    modport decode (
        output op_valid,
        output op,
        output op_rs1,
        output op_illegal
    );

    // Consumer side
    modport execute (
        input op_valid,
        input op,
        input op_rs1,
        input op_illegal
    );

endinterface

// ==== source/sha256_sigma_unit.sv ====
/*
 * SHA-256 sigma and sum functions on the low word of rs1.
 * Result is sign-extended to 64 bits, zero for other opcodes.
 */
`timescale 1ns/1ps

module sha256_sigma_unit (
    input  crypto_pkg::crypto_op_e          op,
    input  logic [crypto_pkg::xlen-1:0]     rs1,
    output logic [crypto_pkg::xlen-1:0]     result
);
    import crypto_pkg::*;

    logic [sha256_w-1:0] w;
    logic [sha256_w-1:0] sig0;
    logic [sha256_w-1:0] sig1;
    logic [sha256_w-1:0] sum0;
    logic [sha256_w-1:0] sum1;
    logic [sha256_w-1:0] sel;

    // 32-bit rotate right
    function automatic logic [sha256_w-1:0] ror32(input logic [sha256_w-1:0] a,
                                                   input int unsigned n);
        return (a >> n) | (a << (sha256_w - n));
    endfunction

    // Upper half of rs1 is ignored
    assign w = rs1[sha256_w-1:0];

    // Message schedule sigmas
    assign sig0 = ror32(w, 7) ^ ror32(w, 18) ^ (w >> 3);
    assign sig1 = ror32(w, 17) ^ ror32(w, 19) ^ (w >> 10);
    // Compression sums
    assign sum0 = ror32(w, 2) ^ ror32(w, 13) ^ ror32(w, 22);
    assign sum1 = ror32(w, 6) ^ ror32(w, 11) ^ ror32(w, 25);

    always_comb begin
        case (op)
            op_sha256sig0: sel = sig0;
            op_sha256sig1: sel = sig1;
            op_sha256sum0: sel = sum0;
            op_sha256sum1: sel = sum1;
            default:       sel = '0;
        endcase
    end

    // Sign extension from bit 31
    assign result = {{(xlen - sha256_w){sel[sha256_w-1]}}, sel};

endmodule

// ==== source/sha512_sigma_unit.sv ====
/*
 * SHA-512 sigma and sum functions on the full 64-bit rs1.
 * AND-OR selection by opcode, zero for other opcodes.
 */
`timescale 1ns/1ps

module sha512_sigma_unit (
    input  crypto_pkg::crypto_op_e          op,
    input  logic [crypto_pkg::xlen-1:0]     rs1,
    output logic [crypto_pkg::xlen-1:0]     result
);
    import crypto_pkg::*;

    logic [xlen-1:0] sig0;
    logic [xlen-1:0] sig1;
    logic [xlen-1:0] sum0;
    logic [xlen-1:0] sum1;

    logic sel_sig0;
    logic sel_sig1;
    logic sel_sum0;
    logic sel_sum1;

    // 64-bit rotate right
    function automatic logic [xlen-1:0] ror64(input logic [xlen-1:0] a,
                                               input int unsigned n);
        return (a >> n) | (a << (xlen - n));
    endfunction

    //------------------------------------------------------------
    // Functions
    //------------------------------------------------------------

    // Message schedule sigmas
    assign sig0 = ror64(rs1, 1) ^ ror64(rs1, 8) ^ (rs1 >> 7);
    assign sig1 = ror64(rs1, 19) ^ ror64(rs1, 61) ^ (rs1 >> 6);
    // Compression sums
    assign sum0 = ror64(rs1, 28) ^ ror64(rs1, 34) ^ ror64(rs1, 39);
    assign sum1 = ror64(rs1, 14) ^ ror64(rs1, 18) ^ ror64(rs1, 41);

    //------------------------------------------------------------
    // Select
    //------------------------------------------------------------

    // One-hot selects from the opcode
    assign sel_sig0 = (op == op_sha512sig0);
    assign sel_sig1 = (op == op_sha512sig1);
    assign sel_sum0 = (op == op_sha512sum0);
    assign sel_sum1 = (op == op_sha512sum1);

    // No select set gives zero
    assign result = ({xlen{sel_sig0}} & sig0) |
                    ({xlen{sel_sig1}} & sig1) |
                    ({xlen{sel_sum0}} & sum0) |
                    ({xlen{sel_sum1}} & sum1);

endmodule

// ==== source/crypto_decode.sv ====
/*
 * Decode stage of the SHA-2 crypto unit.
 * Matches the instruction word against the OP-IMM SHA encodings
 * and registers the decoded operation together with rs1.
 */
`timescale 1ns/1ps

module crypto_decode (
    input  logic                        g_clk,
    input  logic                        rst_n,
    input  logic                        valid,
    input  logic [crypto_pkg::word_w-1:0] instr,
    input  logic [crypto_pkg::xlen-1:0]   rs1,
    crypto_op_if.decode                 op_bus
);
    import crypto_pkg::*;

    crypto_op_e dec_op;
    logic       fields_ok;
    logic       legal;

    //------------------------------------------------------------
    // Field match
    //------------------------------------------------------------

    // rd and rs1 fields are don't care
    assign fields_ok = (instr[6:0] == opc_op_imm) && (instr[14:12] == funct3_sha);

    // Immediate picks the function
    always_comb begin
        case (instr[31:20])
            imm_sha256sig0: dec_op = op_sha256sig0;
            imm_sha256sig1: dec_op = op_sha256sig1;
            imm_sha256sum0: dec_op = op_sha256sum0;
            imm_sha256sum1: dec_op = op_sha256sum1;
            imm_sha512sig0: dec_op = op_sha512sig0;
            imm_sha512sig1: dec_op = op_sha512sig1;
            imm_sha512sum0: dec_op = op_sha512sum0;
            imm_sha512sum1: dec_op = op_sha512sum1;
            default:        dec_op = op_none;
        endcase
    end

    // Legal only with both fields and a known immediate
    assign legal = fields_ok && (dec_op != op_none);

    //------------------------------------------------------------
    // Stage register
    //------------------------------------------------------------

    // Strobes and opcode, mutually exclusive by construction
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            op_bus.op_valid   <= 1'b0;
            op_bus.op_illegal <= 1'b0;
            op_bus.op         <= op_none;
        end else begin
            op_bus.op_valid   <= valid && legal;
            op_bus.op_illegal <= valid && !legal;
            // Idle cycles carry op_none
            op_bus.op         <= (valid && legal) ? dec_op : op_none;
        end
    end

    // Operand is held between strobes
    always_ff @(posedge g_clk) begin
        if (valid) begin
            op_bus.op_rs1 <= rs1;
        end
    end

endmodule

// ==== source/crypto_execute.sv ====
/*
 * Execute stage of the SHA-2 crypto unit, purely combinational.
 * Both sigma units see the same operation and their results are ORed.
 */
`timescale 1ns/1ps

module crypto_execute (
    crypto_op_if.execute                op_bus,
    output logic                        ex_valid,
    output logic                        ex_illegal,
    output logic [crypto_pkg::xlen-1:0] ex_result
);
    import crypto_pkg::*;

    logic [xlen-1:0] res_256;
    logic [xlen-1:0] res_512;
    logic [xlen-1:0] res_any;

    //------------------------------------------------------------
    // Function units
    //------------------------------------------------------------

    sha256_sigma_unit u_sha256 (
        .op     (op_bus.op),
        .rs1    (op_bus.op_rs1),
        .result (res_256)
    );

    sha512_sigma_unit u_sha512 (
        .op     (op_bus.op),
        .rs1    (op_bus.op_rs1),
        .result (res_512)
    );

    //------------------------------------------------------------
    // Merge
    //------------------------------------------------------------

    // Each unit is zero outside its own opcodes
    assign res_any = res_256 | res_512;

    // Zero without op_valid, keeps rd clean downstream
    assign ex_result = op_bus.op_valid ? res_any : '0;

    // Strobes pass straight through
    assign ex_valid   = op_bus.op_valid;
    assign ex_illegal = op_bus.op_illegal;

endmodule

// ==== source/crypto_result.sv ====
/*
 * Result stage of the SHA-2 crypto unit.
 * Registers rd and the result and illegal strobes.
 */
`timescale 1ns/1ps

module crypto_result (
    input  logic                        g_clk,
    input  logic                        rst_n,
    input  logic                        ex_valid,
    input  logic                        ex_illegal,
    input  logic [crypto_pkg::xlen-1:0] ex_result,
    output logic                        rd_valid,
    output logic                        illegal,
    output logic [crypto_pkg::xlen-1:0] rd
);
    import crypto_pkg::*;

    //------------------------------------------------------------
    // Output register
    //------------------------------------------------------------

    // Captured every cycle, no stall
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            illegal  <= 1'b0;
            // rd must read zero out of reset
            rd       <= {xlen{1'b0}};
        end else begin
            rd_valid <= ex_valid;
            illegal  <= ex_illegal;
            // Already zero when ex_valid is low
            rd       <= ex_result;
        end
    end

endmodule

// ==== source/crypto_fu_top.sv ====
/*
 * RV64 SHA-2 scalar crypto functional unit, top level.
 * Decode, execute and result stages, fixed 2-cycle latency.
 */
`timescale 1ns/1ps

module crypto_fu_top (
    input  logic                          g_clk,
    input  logic                          rst_n,
    input  logic                          valid,
    input  logic [crypto_pkg::word_w-1:0] instr,
    input  logic [crypto_pkg::xlen-1:0]   rs1,
    output logic                          rd_valid,
    output logic                          illegal,
    output logic [crypto_pkg::xlen-1:0]   rd
);
    import crypto_pkg::*;

    // Execute to result
    logic            ex_valid;
    logic            ex_illegal;
    logic [xlen-1:0] ex_result;

    // Decode to execute
    crypto_op_if op_bus ();

    //------------------------------------------------------------
    // Stages
    //------------------------------------------------------------

    crypto_decode u_decode (
        .g_clk  (g_clk),
        .rst_n  (rst_n),
        .valid  (valid),
        .instr  (instr),
        .rs1    (rs1),
        .op_bus (op_bus.decode)
    );

    crypto_execute u_execute (
        .op_bus     (op_bus.execute),
        .ex_valid   (ex_valid),
        .ex_illegal (ex_illegal),
        .ex_result  (ex_result)
    );

    crypto_result u_result (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_illegal (ex_illegal),
        .ex_result  (ex_result),
        .rd_valid   (rd_valid),
        .illegal    (illegal),
        .rd         (rd)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
/*
 * Testbench clock source, 100 ns period.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic g_clk
);

    // Half of the 100 ns period
    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

endmodule

// ==== tb/crypto_fu_properties.sv ====
/*
 * Concurrent checks on the crypto unit strobes and latency.
 * Bound into crypto_fu_top.
 */
`timescale 1ns/1ps

module crypto_fu_properties (
    input logic                        g_clk,
    input logic                        rst_n,
    input logic                        valid,
    input logic                        rd_valid,
    input logic                        illegal,
    input logic [crypto_pkg::xlen-1:0] rd
);

    // Result and illegal strobes are exclusive
    a_strobe_excl: assert property (@(posedge g_clk) disable iff (!rst_n)
        !(rd_valid && illegal))
        else $error("rd_valid and illegal high in the same cycle");

    // No stale data on rd
    a_rd_zero: assert property (@(posedge g_clk) disable iff (!rst_n)
        !rd_valid |-> (rd == '0))
        else $error("rd not zero while rd_valid is low");

    // Fixed 2-cycle latency, one answer per issue
    a_latency: assert property (@(posedge g_clk) disable iff (!rst_n)
        valid |-> ##2 (rd_valid ^ illegal))
        else $error("no single response two cycles after valid");

endmodule

bind crypto_fu_top crypto_fu_properties u_props (
    .g_clk    (g_clk),
    .rst_n    (rst_n),
    .valid    (valid),
    .rd_valid (rd_valid),
    .illegal  (illegal),
    .rd       (rd)
);

// ==== tb/crypto_fu_tb.sv ====
/*
 * Directed testbench for the RV64 SHA-2 crypto unit.
 * LFSR operands, reference model and a 2-cycle expected-result queue.
 */
`timescale 1ns/1ps

module crypto_fu_tb;
    import crypto_pkg::*;

    // Test lengths in cycles, used for the timeout
    localparam int reset_cycles = 5;
    localparam int run_cycles   = 4 * 16 * 2 + 4 * 8 * 3 + 4 * 2 + 24 + 1;
    localparam int cycle_limit  = reset_cycles + run_cycles + 50;

    logic g_clk;
    logic rst_n;
    logic valid;
    logic [word_w-1:0] instr;
    logic [xlen-1:0] rs1;
    logic rd_valid;
    logic illegal;
    logic [xlen-1:0] rd;

    logic [31:0] lfsr_state = 32'd99298;
    logic [65:0] exp_q [$];
    logic [65:0] head;
    logic [64:0] model_out;
    int errors = 0;
    int issued = 0;
    int in_flight = 0;
    int cycles = 0;

    tb_clock_gen u_clk (.g_clk(g_clk));

    crypto_fu_top dut_i (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .valid    (valid),
        .instr    (instr),
        .rs1      (rs1),
        .rd_valid (rd_valid),
        .illegal  (illegal),
        .rd       (rd)
    );

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    // One LFSR step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[62:0], lfsr_step()};
        return r;
    endfunction

    function automatic logic [31:0] rotr32(input logic [31:0] a, input int n);
        return (a >> n) | (a << (32 - n));
    endfunction

    function automatic logic [63:0] rotr64(input logic [63:0] a, input int n);
        return (a >> n) | (a << (64 - n));
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] a);
        return {{32{a[31]}}, a};
    endfunction

    // Reference model, {legal, rd}
    function automatic logic [64:0] model_rd(input logic [31:0] word, input logic [63:0] src);
        logic [31:0] w;
        logic [63:0] r;
        logic ok;
        w = src[31:0];
        r = '0;
        ok = (word[6:0] == opc_op_imm) && (word[14:12] == funct3_sha);
        case (word[31:20])
            imm_sha256sig0: r = sext32(rotr32(w, 7) ^ rotr32(w, 18) ^ (w >> 3));
            imm_sha256sig1: r = sext32(rotr32(w, 17) ^ rotr32(w, 19) ^ (w >> 10));
            imm_sha256sum0: r = sext32(rotr32(w, 2) ^ rotr32(w, 13) ^ rotr32(w, 22));
            imm_sha256sum1: r = sext32(rotr32(w, 6) ^ rotr32(w, 11) ^ rotr32(w, 25));
            imm_sha512sig0: r = rotr64(src, 1) ^ rotr64(src, 8) ^ (src >> 7);
            imm_sha512sig1: r = rotr64(src, 19) ^ rotr64(src, 61) ^ (src >> 6);
            imm_sha512sum0: r = rotr64(src, 28) ^ rotr64(src, 34) ^ rotr64(src, 39);
            imm_sha512sum1: r = rotr64(src, 14) ^ rotr64(src, 18) ^ rotr64(src, 41);
            default:        ok = 1'b0;
        endcase
        if (!ok) r = '0;
        return {ok, r};
    endfunction

    // 0..3 SHA-256 sig0, sig1, sum0, sum1; 4..7 the same for SHA-512
    function automatic logic [11:0] pick_imm(input logic [2:0] i);
        case (i)
            3'd0: return imm_sha256sig0;
            3'd1: return imm_sha256sig1;
            3'd2: return imm_sha256sum0;
            3'd3: return imm_sha256sum1;
            3'd4: return imm_sha512sig0;
            3'd5: return imm_sha512sig1;
            3'd6: return imm_sha512sum0;
            default: return imm_sha512sum1;
        endcase
    endfunction

    // Random rd and rs1 register fields
    function automatic logic [31:0] make_instr(input logic [11:0] imm, input logic [2:0] f3,
                                               input logic [6:0] opc);
        logic [4:0] rdf;
        logic [4:0] rsf;
        rdf = 5'(rand_bits(5));
        rsf = 5'(rand_bits(5));
        return {imm, rsf, f3, rdf, opc};
    endfunction

    // Wrong opcode, wrong funct3, immediate 0x108, immediate 0x0FF
    function automatic logic [31:0] bad_instr(input logic [1:0] k);
        case (k)
            2'd0: return make_instr(imm_sha256sum0, funct3_sha, 7'h33);
            2'd1: return make_instr(imm_sha512sig0, 3'd5, opc_op_imm);
            2'd2: return make_instr(12'h108, funct3_sha, opc_op_imm);
            default: return make_instr(12'h0FF, funct3_sha, opc_op_imm);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive(input logic v, input logic [31:0] word, input logic [63:0] data);
        @(posedge g_clk);
        #10;
        valid = v;
        instr = word;
        rs1   = data;
        if (v) issued++;
    endtask

    //------------------------------------------------------------
    // Scoreboard and timeout
    //------------------------------------------------------------

    // Inputs stable at the falling edge, answer two falling edges later
    always @(negedge g_clk) begin
        if (rst_n) begin
            if (valid) begin
                model_out = model_rd(instr, rs1);
                exp_q.push_back({model_out[64], !model_out[64], model_out[63:0]});
                in_flight++;
            end else begin
                exp_q.push_back('0);
            end
            if (exp_q.size() > 2) begin
                head = exp_q.pop_front();
                check_value("rd_valid", 64'(rd_valid), 64'(head[65]));
                check_value("illegal", 64'(illegal), 64'(head[64]));
                check_value("rd", rd, head[63:0]);
                if (head[65] || head[64]) in_flight--;
            end
        end
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d results outstanding", cycles, in_flight);
            $display("tests failed");
            $finish;
        end
    end

    //------------------------------------------------------------
    // Tests
    //------------------------------------------------------------

    task automatic test_reset();
        @(negedge g_clk);
        check_value("rd_valid", 64'(rd_valid), 64'd0);
        check_value("illegal", 64'(illegal), 64'd0);
        check_value("rd", rd, 64'd0);
    endtask

    task automatic test_sha512();
        for (int f = 4; f < 8; f++) begin
            for (int i = 0; i < 16; i++) begin
                drive(1'b1, make_instr(pick_imm(3'(f)), funct3_sha, opc_op_imm), rand_bits(64));
                drive(1'b0, '0, '0);
            end
        end
    endtask

    // Same low word twice with new upper halves
    task automatic test_sha256();
        logic [63:0] base;
        logic [63:0] upper;
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 8; i++) begin
                base = rand_bits(64);
                drive(1'b1, make_instr(pick_imm(3'(f)), funct3_sha, opc_op_imm), base);
                upper = rand_bits(32);
                drive(1'b1, make_instr(pick_imm(3'(f)), funct3_sha, opc_op_imm),
                      {upper[31:0], base[31:0]});
                drive(1'b0, '0, '0);
            end
        end
    endtask

    task automatic test_illegal();
        for (int k = 0; k < 4; k++) begin
            drive(1'b1, bad_instr(2'(k)), rand_bits(64));
            drive(1'b0, '0, '0);
        end
    endtask

    // Half legal, half illegal, no gaps
    task automatic test_back_to_back();
        logic [3:0] sel;
        for (int i = 0; i < 24; i++) begin
            sel = 4'(rand_bits(4));
            if (!sel[3]) drive(1'b1, make_instr(pick_imm(sel[2:0]), funct3_sha, opc_op_imm),
                               rand_bits(64));
            else drive(1'b1, bad_instr(sel[1:0]), rand_bits(64));
        end
        drive(1'b0, '0, '0);
    endtask

    initial begin
        rst_n = 1'b0;
        valid = 1'b0;
        instr = '0;
        rs1   = '0;
        repeat (reset_cycles) @(posedge g_clk);
        #10;
        rst_n = 1'b1;
        test_reset();
        test_sha512();
        test_sha256();
        test_illegal();
        test_back_to_back();
        // Drain the pipeline
        while (in_flight != 0) @(posedge g_clk);
        $display("Errors: %0d, instructions issued: %0d", errors, issued);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/crypto_pkg.sv
source/crypto_op_if.sv
source/sha256_sigma_unit.sv
source/sha512_sigma_unit.sv
source/crypto_decode.sv
source/crypto_execute.sv
source/crypto_result.sv
source/crypto_fu_top.sv
tb/tb_clock_gen.sv
tb/crypto_fu_properties.sv
tb/crypto_fu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crypto unit testbench with Verilator
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -f src.f --top-module crypto_fu_tb -o sim &&
./obj_dir/sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "PASS" && exit 0 ||
{ echo "FAIL"; exit 1; }
